/* common/dcache_macros.svh */
// fixed cache geometry; line width must be a power-of-two multiple of XLEN and sets a power of two
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// associativity
`define DCACHE_WAYS 4

// word width, one data bank holds one word per way
`define DCACHE_XLEN 32

// 128 bit line gives four banks, bank picked by offset bits 3:2
`define DCACHE_LINE_WIDTH 128

// 16 sets, 4 bit index
`define DCACHE_NUM_SETS 16

`define DCACHE_TAG_WIDTH 8

// read ports sharing the arrays
`define DCACHE_NUM_PORTS 3

`endif

/* common/dcache_pkg.sv */
// types of the dcache memory block; widths follow dcache_macros.svh, no user or sideband bits
`include "dcache_macros.svh"

package dcache_pkg;

  localparam int unsigned NUM_BANKS  = `DCACHE_LINE_WIDTH / `DCACHE_XLEN;
  localparam int unsigned BYTE_W     = `DCACHE_XLEN / 8;
  localparam int unsigned IDX_W      = $clog2(`DCACHE_NUM_SETS);
  localparam int unsigned OFF_W      = $clog2(`DCACHE_LINE_WIDTH / 8);
  localparam int unsigned BANK_SEL_W = $clog2(NUM_BANKS);
  localparam int unsigned PORT_SEL_W = $clog2(`DCACHE_NUM_PORTS);
  localparam int unsigned WAY_SEL_W  = $clog2(`DCACHE_WAYS);

  typedef logic [IDX_W-1:0]              idx_t;
  typedef logic [OFF_W-1:0]              off_t;
  typedef logic [BANK_SEL_W-1:0]         bank_sel_t;
  typedef logic [PORT_SEL_W-1:0]         port_sel_t;
  typedef logic [`DCACHE_NUM_PORTS-1:0]  port_mask_t;
  typedef logic [`DCACHE_WAYS-1:0]       way_mask_t;
  typedef logic [NUM_BANKS-1:0]          bank_mask_t;
  typedef logic [`DCACHE_TAG_WIDTH-1:0]  tag_t;

  typedef struct packed {
    logic req;
    logic prio;
    logic tag_only;
    idx_t idx;
    off_t off;
  } rd_req_t;

  typedef rd_req_t [`DCACHE_NUM_PORTS-1:0] rd_req_arr_t;
  typedef tag_t    [`DCACHE_NUM_PORTS-1:0] rd_tag_arr_t;

  typedef struct packed {
    logic vld;
    tag_t tag;
  } tag_entry_t;

  typedef tag_entry_t [`DCACHE_WAYS-1:0] tag_row_t;

  // one word per way, one bank each
  typedef logic [`DCACHE_WAYS-1:0][`DCACHE_XLEN-1:0] data_row_t;
  typedef logic [`DCACHE_WAYS-1:0][BYTE_W-1:0]       data_be_t;

  typedef data_row_t [NUM_BANKS-1:0] data_bank_arr_t;
  typedef data_be_t  [NUM_BANKS-1:0] be_bank_arr_t;
  typedef idx_t      [NUM_BANKS-1:0] bank_idx_arr_t;

  typedef struct packed {
    logic                                 vld;
    way_mask_t                            we;
    tag_t                                 tag;
    idx_t                                 idx;
    logic [`DCACHE_LINE_WIDTH-1:0]        data;
    logic [`DCACHE_LINE_WIDTH/8-1:0]      be;
    way_mask_t                            vld_bits;
  } cl_wr_t;

  typedef struct packed {
    way_mask_t               req;
    idx_t                    idx;
    off_t                    off;
    logic [`DCACHE_XLEN-1:0] data;
    logic [BYTE_W-1:0]       be;
  } word_wr_t;

  typedef struct packed {
    way_mask_t               vld_bits;
    way_mask_t               hit_oh;
    logic [`DCACHE_XLEN-1:0] data;
  } rd_rsp_t;

endpackage

/* arbiter/dcache_rd_arbiter.sv */
// no read is granted while a line write is valid; high priority requests starve low priority ones
`timescale 1ns/100ps
`include "dcache_macros.svh"

module dcache_rd_arbiter (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  dcache_pkg::rd_req_arr_t rd_req_i,
  input  logic                    cl_vld_i,
  output dcache_pkg::port_mask_t  rd_ack_o,
  output dcache_pkg::port_sel_t   sel_o,
  output logic                    acked_o
);
  import dcache_pkg::*;

  port_mask_t req;
  port_mask_t req_prio;
  port_mask_t req_masked;
  port_sel_t  last_q;
  logic       found;

  //////////////////////////////////////////////////
  // priority mask
  //////////////////////////////////////////////////

  always_comb begin : p_mask
    for (int p = 0; p < `DCACHE_NUM_PORTS; p++) begin
      req[p]      = rd_req_i[p].req;
      req_prio[p] = rd_req_i[p].req & rd_req_i[p].prio;
    end
    // only high prio ports compete if any is present
    req_masked = (|req_prio) ? req_prio : req;
  end

  //////////////////////////////////////////////////
  // round robin search
  //////////////////////////////////////////////////

  // start one past the last winner and wrap around
  always_comb begin : p_search
    int cand;
    sel_o = last_q;
    found = 1'b0;
    for (int k = 1; k <= `DCACHE_NUM_PORTS; k++) begin
      cand = (int'(last_q) + k) % `DCACHE_NUM_PORTS;
      if (!found && req_masked[cand]) begin
        found = 1'b1;
        sel_o = port_sel_t'(cand);
      end
    end
  end

  assign acked_o = found & ~cl_vld_i;

  always_comb begin : p_ack
    rd_ack_o = '0;
    if (acked_o) begin
      rd_ack_o[sel_o] = 1'b1;
    end
  end

  // pointer starts at the last port so port 0 wins first
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_last
    if (!rst_ni) begin
      last_q <= port_sel_t'(`DCACHE_NUM_PORTS - 1);
    end else if (acked_o) begin
      last_q <= sel_o;
    end
  end

endmodule

/* arbiter/dcache_bank_ctrl.sv */
// line write owns every bank; word write only proceeds when its bank is free of a granted data read
`timescale 1ns/100ps
`include "dcache_macros.svh"

module dcache_bank_ctrl (
  input  dcache_pkg::rd_req_t        sel_req_i,
  input  logic                       acked_i,
  input  dcache_pkg::cl_wr_t         cl_wr_i,
  input  dcache_pkg::word_wr_t       word_wr_i,
  output logic                       wr_ack_o,
  output dcache_pkg::way_mask_t      tag_req_o,
  output logic                       tag_we_o,
  output dcache_pkg::idx_t           tag_addr_o,
  output dcache_pkg::tag_row_t       tag_wdata_o,
  output dcache_pkg::bank_mask_t     bank_req_o,
  output dcache_pkg::bank_mask_t     bank_we_o,
  output dcache_pkg::bank_idx_arr_t  bank_addr_o,
  output dcache_pkg::data_bank_arr_t bank_wdata_o,
  output dcache_pkg::be_bank_arr_t   bank_be_o
);
  import dcache_pkg::*;

  logic      cl_write;
  logic      rd_data;
  logic      collide;
  bank_sel_t rd_bank;
  bank_sel_t wr_bank;

  assign cl_write = cl_wr_i.vld & (|cl_wr_i.we);
  assign rd_bank  = sel_req_i.off[OFF_W-1 -: BANK_SEL_W];
  assign wr_bank  = word_wr_i.off[OFF_W-1 -: BANK_SEL_W];

  // tag only reads leave the data banks alone
  assign rd_data  = acked_i & ~sel_req_i.tag_only;
  assign collide  = rd_data & (rd_bank == wr_bank);
  assign wr_ack_o = (|word_wr_i.req) & ~cl_wr_i.vld & ~collide;

  //////////////////////////////////////////////////
  // tag array
  //////////////////////////////////////////////////

  assign tag_we_o   = cl_write;
  assign tag_req_o  = cl_write ? cl_wr_i.we : (acked_i ? '1 : '0);
  assign tag_addr_o = cl_write ? cl_wr_i.idx : sel_req_i.idx;

  always_comb begin : p_tag_wdata
    for (int w = 0; w < `DCACHE_WAYS; w++) begin
      tag_wdata_o[w].vld = cl_wr_i.vld_bits[w];
      tag_wdata_o[w].tag = cl_wr_i.tag;
    end
  end

  //////////////////////////////////////////////////
  // data banks
  //////////////////////////////////////////////////

  always_comb begin : p_banks
    for (int b = 0; b < NUM_BANKS; b++) begin
      bank_req_o[b]  = 1'b0;
      bank_we_o[b]   = 1'b0;
      bank_addr_o[b] = word_wr_i.idx;
      // spread the line over banks, one word per bank and way
      for (int w = 0; w < `DCACHE_WAYS; w++) begin
        if (cl_write) begin
          bank_wdata_o[b][w] = cl_wr_i.data[b*`DCACHE_XLEN +: `DCACHE_XLEN];
          bank_be_o[b][w]    = cl_wr_i.we[w] ? cl_wr_i.be[b*BYTE_W +: BYTE_W] : '0;
        end else begin
          bank_wdata_o[b][w] = word_wr_i.data;
          bank_be_o[b][w]    = (wr_ack_o && word_wr_i.req[w] && wr_bank == bank_sel_t'(b)) ?
                               word_wr_i.be : '0;
        end
      end
      if (cl_write) begin
        bank_req_o[b]  = 1'b1;
        bank_we_o[b]   = 1'b1;
        bank_addr_o[b] = cl_wr_i.idx;
      end else begin
        if (rd_data && rd_bank == bank_sel_t'(b)) begin
          bank_req_o[b]  = 1'b1;
          bank_addr_o[b] = sel_req_i.idx;
        end
        // never the read bank, collide already blocked that case
        if (wr_ack_o && wr_bank == bank_sel_t'(b)) begin
          bank_req_o[b] = 1'b1;
          bank_we_o[b]  = 1'b1;
        end
      end
    end
  end

endmodule

/* src/cache_sram.sv */
// contents are not reset; row width must equal mask bits times MaskGrain; rdata holds during writes
`timescale 1ns/100ps
`include "dcache_macros.svh"

module cache_sram #(
  parameter type         row_t     = logic,
  parameter type         mask_t    = logic,
  parameter int unsigned MaskGrain = 8
) (
  input  logic                                clk_i,
  input  logic                                req_i,
  input  logic                                we_i,
  input  logic [$clog2(`DCACHE_NUM_SETS)-1:0] addr_i,
  input  row_t                                wdata_i,
  input  mask_t                               mask_i,
  output row_t                                rdata_o
);

  localparam int unsigned RowBits   = $bits(row_t);
  localparam int unsigned NumGrains = $bits(mask_t);

  logic [RowBits-1:0]   mem_q [`DCACHE_NUM_SETS];
  logic [RowBits-1:0]   wbits;
  logic [NumGrains-1:0] wmask;
  logic [RowBits-1:0]   rdata_q;

  assign wbits   = wdata_i;
  assign wmask   = mask_i;
  assign rdata_o = row_t'(rdata_q);

  always_ff @(posedge clk_i) begin : p_array
    if (req_i) begin
      if (we_i) begin
        for (int unsigned g = 0; g < NumGrains; g++) begin
          if (wmask[g]) begin
            mem_q[addr_i][g*MaskGrain +: MaskGrain] <= wbits[g*MaskGrain +: MaskGrain];
          end
        end
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

endmodule

/* src/dcache_hit_select.sv */
// rd_tag_i of the granted port is sampled one cycle after its ack; data is zero on a miss or tag-only read
`timescale 1ns/100ps
`include "dcache_macros.svh"

module dcache_hit_select (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  dcache_pkg::port_sel_t      sel_i,
  input  logic                       acked_i,
  input  logic                       tag_only_i,
  input  dcache_pkg::off_t           off_i,
  input  dcache_pkg::rd_tag_arr_t    rd_tag_i,
  input  dcache_pkg::tag_row_t       tag_rdata_i,
  input  dcache_pkg::data_bank_arr_t bank_rdata_i,
  output dcache_pkg::rd_rsp_t        rd_rsp_o
);
  import dcache_pkg::*;

  port_sel_t            sel_q;
  bank_sel_t            bank_q;
  logic                 cmp_en_q;
  logic                 data_en_q;
  way_mask_t            vld_bits;
  way_mask_t            hit_oh;
  logic [WAY_SEL_W-1:0] hit_idx;

  //////////////////////////////////////////////////
  // request stage
  //////////////////////////////////////////////////

  // arbiter already holds off acks during line writes
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      sel_q     <= '0;
      bank_q    <= '0;
      cmp_en_q  <= 1'b0;
      data_en_q <= 1'b0;
    end else begin
      sel_q     <= sel_i;
      bank_q    <= off_i[OFF_W-1 -: BANK_SEL_W];
      cmp_en_q  <= acked_i;
      data_en_q <= acked_i & ~tag_only_i;
    end
  end

  //////////////////////////////////////////////////
  // tag compare and word select
  //////////////////////////////////////////////////

  always_comb begin : p_hit
    for (int w = 0; w < `DCACHE_WAYS; w++) begin
      vld_bits[w] = tag_rdata_i[w].vld;
      hit_oh[w]   = (tag_rdata_i[w].tag == rd_tag_i[sel_q]) & tag_rdata_i[w].vld & cmp_en_q;
    end
  end

  // lowest hitting way wins, walk down so it is written last
  always_comb begin : p_way_sel
    hit_idx = '0;
    for (int w = `DCACHE_WAYS - 1; w >= 0; w--) begin
      if (hit_oh[w]) begin
        hit_idx = WAY_SEL_W'(w);
      end
    end
  end

  assign rd_rsp_o.vld_bits = vld_bits;
  assign rd_rsp_o.hit_oh   = hit_oh;
  assign rd_rsp_o.data     = (data_en_q && |hit_oh) ? bank_rdata_i[bank_q][hit_idx] : '0;

endmodule

/* src/dcache_mem.sv */
// read response comes one cycle after rd_ack_o; tag and data arrays power up unknown, invalidate first
`timescale 1ns/100ps

module dcache_mem (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  dcache_pkg::rd_req_arr_t rd_req_i,
  input  dcache_pkg::rd_tag_arr_t rd_tag_i,
  output dcache_pkg::port_mask_t  rd_ack_o,
  input  dcache_pkg::cl_wr_t      cl_wr_i,
  input  dcache_pkg::word_wr_t    word_wr_i,
  output logic                    wr_ack_o,
  output dcache_pkg::rd_rsp_t     rd_rsp_o
);
  import dcache_pkg::*;

  port_sel_t      sel;
  logic           acked;
  rd_req_t        sel_req;
  way_mask_t      tag_req;
  logic           tag_we;
  idx_t           tag_addr;
  tag_row_t       tag_wdata;
  tag_row_t       tag_rdata;
  bank_mask_t     bank_req;
  bank_mask_t     bank_we;
  bank_idx_arr_t  bank_addr;
  data_bank_arr_t bank_wdata;
  data_bank_arr_t bank_rdata;
  be_bank_arr_t   bank_be;

  // request of the granted port
  assign sel_req = rd_req_i[sel];

  dcache_rd_arbiter i_rd_arbiter (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .rd_req_i (rd_req_i),
    .cl_vld_i (cl_wr_i.vld),
    .rd_ack_o (rd_ack_o),
    .sel_o    (sel),
    .acked_o  (acked)
  );

  dcache_bank_ctrl i_bank_ctrl (
    .sel_req_i    (sel_req),
    .acked_i      (acked),
    .cl_wr_i      (cl_wr_i),
    .word_wr_i    (word_wr_i),
    .wr_ack_o     (wr_ack_o),
    .tag_req_o    (tag_req),
    .tag_we_o     (tag_we),
    .tag_addr_o   (tag_addr),
    .tag_wdata_o  (tag_wdata),
    .bank_req_o   (bank_req),
    .bank_we_o    (bank_we),
    .bank_addr_o  (bank_addr),
    .bank_wdata_o (bank_wdata),
    .bank_be_o    (bank_be)
  );

  //////////////////////////////////////////////////
  // arrays
  //////////////////////////////////////////////////

  // way mask doubles as write mask, one 9 bit grain per way
  cache_sram #(
    .row_t     (tag_row_t),
    .mask_t    (way_mask_t),
    .MaskGrain ($bits(tag_entry_t))
  ) i_tag_sram (
    .clk_i   (clk_i),
    .req_i   (|tag_req),
    .we_i    (tag_we),
    .addr_i  (tag_addr),
    .wdata_i (tag_wdata),
    .mask_i  (tag_req),
    .rdata_o (tag_rdata)
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_data_bank
    cache_sram #(
      .row_t     (data_row_t),
      .mask_t    (data_be_t),
      .MaskGrain (8)
    ) i_data_sram (
      .clk_i   (clk_i),
      .req_i   (bank_req[b]),
      .we_i    (bank_we[b]),
      .addr_i  (bank_addr[b]),
      .wdata_i (bank_wdata[b]),
      .mask_i  (bank_be[b]),
      .rdata_o (bank_rdata[b])
    );
  end

  dcache_hit_select i_hit_select (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .sel_i        (sel),
    .acked_i      (acked),
    .tag_only_i   (sel_req.tag_only),
    .off_i        (sel_req.off),
    .rd_tag_i     (rd_tag_i),
    .tag_rdata_i  (tag_rdata),
    .bank_rdata_i (bank_rdata),
    .rd_rsp_o     (rd_rsp_o)
  );

endmodule

/* testbench/tb_clk_gen.sv */
// free running 8 ns clock; reset is held low for the first 4 rising edges, then released 1 ns later
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int unsigned HalfPeriod  = 4;
  localparam int unsigned ResetCycles = 4;

  initial begin : p_clk
    clk_o = 1'b0;
    forever begin
      #(HalfPeriod) clk_o = ~clk_o;
    end
  end

  // release off the edge, same as the other stimulus
  initial begin : p_rst
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

/* testbench/tb_dcache_mem.sv */
// stimulus changes 1 ns after the rising edge, outputs are sampled 5 ns after it; stops at first error
`timescale 1ns/100ps
`include "dcache_macros.svh"

module tb_dcache_mem;
  import dcache_pkg::*;

  typedef logic [`DCACHE_XLEN-1:0]       word_t;
  typedef logic [`DCACHE_LINE_WIDTH-1:0] line_t;

  // rsp_tag and exp_rsp of a table row belong to the cycle after it
  typedef struct {
    rd_req_arr_t rd_req;
    rd_tag_arr_t rsp_tag;
    cl_wr_t      cl_wr;
    word_wr_t    word_wr;
    port_mask_t  exp_rd_ack;
    logic        exp_wr_ack;
    logic        chk_rsp;
    logic        chk_data;
    rd_rsp_t     exp_rsp;
  } row_t;

  logic        clk;
  logic        rst_n;
  rd_req_arr_t rd_req;
  rd_tag_arr_t rd_tag;
  port_mask_t  rd_ack;
  cl_wr_t      cl_wr;
  word_wr_t    word_wr;
  logic        wr_ack;
  rd_rsp_t     rd_rsp;

  row_t        rows[$];
  integer      seed;
  int unsigned cycles      = 0;
  int unsigned cycle_limit = 0;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  dcache_mem u_dut (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .rd_req_i  (rd_req),
    .rd_tag_i  (rd_tag),
    .rd_ack_o  (rd_ack),
    .cl_wr_i   (cl_wr),
    .word_wr_i (word_wr),
    .wr_ack_o  (wr_ack),
    .rd_rsp_o  (rd_rsp)
  );

  //////////////////////////////////////////////////
  // row builders
  //////////////////////////////////////////////////

  function automatic row_t idle_row();
    row_t r;
    r.rd_req     = '0;
    r.rsp_tag    = '0;
    r.cl_wr      = '0;
    r.word_wr    = '0;
    r.exp_rd_ack = '0;
    r.exp_wr_ack = 1'b0;
    r.chk_rsp    = 1'b0;
    r.chk_data   = 1'b0;
    r.exp_rsp    = '0;
    return r;
  endfunction

  function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                        input logic [BYTE_W-1:0] be);
    word_t w;
    w = old_word;
    for (int k = 0; k < BYTE_W; k++) begin
      if (be[k]) begin
        w[k*8 +: 8] = new_word[k*8 +: 8];
      end
    end
    return w;
  endfunction

  function automatic cl_wr_t line_write(input way_mask_t we, input tag_t tag, input idx_t idx,
                                        input line_t data, input way_mask_t vld_bits);
    cl_wr_t c;
    c.vld      = 1'b1;
    c.we       = we;
    c.tag      = tag;
    c.idx      = idx;
    c.data     = data;
    c.be       = '1;
    c.vld_bits = vld_bits;
    return c;
  endfunction

  function automatic word_wr_t word_write(input way_mask_t req, input idx_t idx, input off_t off,
                                          input word_t data, input logic [BYTE_W-1:0] be);
    word_wr_t w;
    w.req  = req;
    w.idx  = idx;
    w.off  = off;
    w.data = data;
    w.be   = be;
    return w;
  endfunction

  // a lone requester without a line write is always acked
  function automatic row_t single_read(input int port, input idx_t idx, input off_t off,
                                       input tag_t tag, input way_mask_t vld_bits,
                                       input way_mask_t hit_oh, input word_t data);
    row_t r;
    r = idle_row();
    r.rd_req[port]       = '{req: 1'b1, prio: 1'b0, tag_only: 1'b0, idx: idx, off: off};
    r.rsp_tag[port]      = tag;
    r.exp_rd_ack[port]   = 1'b1;
    r.chk_rsp            = 1'b1;
    r.chk_data           = |hit_oh;
    r.exp_rsp            = '{vld_bits: vld_bits, hit_oh: hit_oh, data: data};
    return r;
  endfunction

  // port p reads set 5 at bank p, where way 2 holds the line
  function automatic row_t all_ports_read(input port_mask_t prio, input port_mask_t exp_ack,
                                          input word_t data);
    row_t r;
    r = idle_row();
    for (int p = 0; p < `DCACHE_NUM_PORTS; p++) begin
      r.rd_req[p]  = '{req: 1'b1, prio: prio[p], tag_only: 1'b0, idx: 4'd5, off: off_t'(p*4)};
      r.rsp_tag[p] = 8'h3c;
    end
    r.exp_rd_ack = exp_ack;
    r.chk_rsp    = |exp_ack;
    r.chk_data   = |exp_ack;
    r.exp_rsp    = '{vld_bits: 4'b0100, hit_oh: 4'b0100, data: data};
    return r;
  endfunction

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped on a failed check");
  endtask

  task automatic check_ack(input port_mask_t act, input port_mask_t exp, input int row);
    if (act !== exp) begin
      $display("ERROR @ %0t: row %0d rd_ack %b, expected %b", $time, row, act, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input logic act, input logic exp, input int row);
    if (act !== exp) begin
      $display("ERROR @ %0t: row %0d wr_ack %b, expected %b", $time, row, act, exp);
      abort_run();
    end
  endtask

  task automatic check_rsp(input rd_rsp_t act, input rd_rsp_t exp, input logic chk_data,
                           input int row);
    if (act.vld_bits !== exp.vld_bits || act.hit_oh !== exp.hit_oh ||
        (chk_data && act.data !== exp.data)) begin
      $display("ERROR @ %0t: row %0d rsp vld %b hit %b data %h, expected %b %b %h",
               $time, row, act.vld_bits, act.hit_oh, act.data,
               exp.vld_bits, exp.hit_oh, exp.data);
      abort_run();
    end
  endtask

  always @(posedge clk) begin : p_timeout
    cycles++;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("timeout: the test did not finish within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin : p_main
    line_t line_a;
    line_t line_b;
    word_t wd_a;
    word_t wd_b;
    word_t wd_c;
    word_t merged;
    row_t  r;
    seed    = 32'h79ce_0805;
    rd_req  = '0;
    rd_tag  = '0;
    cl_wr   = '0;
    word_wr = '0;
    line_a  = {$random(seed), $random(seed), $random(seed), $random(seed)};
    line_b  = {$random(seed), $random(seed), $random(seed), $random(seed)};
    wd_a    = $random(seed);
    wd_b    = $random(seed);
    wd_c    = $random(seed);
    merged  = merge_bytes(line_a[63:32], wd_a, 4'b0101);

    // empty sets miss
    rows.push_back(single_read(0, 4'd3, 4'd0, 8'h00, 4'b0000, 4'b0000, '0));
    rows.push_back(single_read(0, 4'd5, 4'd0, 8'h3c, 4'b0000, 4'b0000, '0));
    rows.push_back(single_read(1, 4'd15, 4'd4, 8'hff, 4'b0000, 4'b0000, '0));
    // fill way 2 of set 5, read back every bank, then a wrong tag
    r = idle_row();
    r.cl_wr = line_write(4'b0100, 8'h3c, 4'd5, line_a, 4'b0100);
    rows.push_back(r);
    for (int b = 0; b < NUM_BANKS; b++) begin
      rows.push_back(single_read(0, 4'd5, off_t'(b*4), 8'h3c, 4'b0100, 4'b0100,
                                 line_a[b*`DCACHE_XLEN +: `DCACHE_XLEN]));
    end
    rows.push_back(single_read(0, 4'd5, 4'd0, 8'h3d, 4'b0100, 4'b0000, '0));
    // partial word write, then tag-only read beside a write to its bank
    r = idle_row();
    r.word_wr    = word_write(4'b0100, 4'd5, 4'd4, wd_a, 4'b0101);
    r.exp_wr_ack = 1'b1;
    rows.push_back(r);
    rows.push_back(single_read(0, 4'd5, 4'd4, 8'h3c, 4'b0100, 4'b0100, merged));
    r = single_read(0, 4'd5, 4'd8, 8'h3c, 4'b0100, 4'b0100, '0);
    r.rd_req[0].tag_only = 1'b1;
    r.chk_data           = 1'b0;
    r.word_wr            = word_write(4'b0100, 4'd5, 4'd8, wd_b, 4'hf);
    r.exp_wr_ack         = 1'b1;
    rows.push_back(r);
    rows.push_back(single_read(0, 4'd5, 4'd8, 8'h3c, 4'b0100, 4'b0100, wd_b));
    // bank collision blocks the word write, another bank lets it through
    r = single_read(0, 4'd5, 4'd12, 8'h3c, 4'b0100, 4'b0100, line_a[127:96]);
    r.word_wr = word_write(4'b0100, 4'd5, 4'd12, wd_c, 4'hf);
    rows.push_back(r);
    r = single_read(0, 4'd5, 4'd0, 8'h3c, 4'b0100, 4'b0100, line_a[31:0]);
    r.word_wr    = word_write(4'b0100, 4'd5, 4'd12, wd_c, 4'hf);
    r.exp_wr_ack = 1'b1;
    rows.push_back(r);
    rows.push_back(single_read(0, 4'd5, 4'd12, 8'h3c, 4'b0100, 4'b0100, wd_c));
    // port 2 wins last, so the rotation starts again at port 0
    rows.push_back(single_read(2, 4'd5, 4'd8, 8'h3c, 4'b0100, 4'b0100, wd_b));
    rows.push_back(all_ports_read(3'b000, 3'b001, line_a[31:0]));
    rows.push_back(all_ports_read(3'b000, 3'b010, merged));
    rows.push_back(all_ports_read(3'b000, 3'b100, wd_b));
    rows.push_back(all_ports_read(3'b000, 3'b001, line_a[31:0]));
    rows.push_back(all_ports_read(3'b100, 3'b100, wd_b));
    rows.push_back(all_ports_read(3'b010, 3'b010, merged));
    // line write holds off every read and the word write
    r = all_ports_read(3'b000, 3'b000, '0);
    r.cl_wr   = line_write(4'b1000, 8'h11, 4'd9, line_b, 4'b1000);
    r.word_wr = word_write(4'b0001, 4'd9, 4'd0, wd_a, 4'hf);
    rows.push_back(r);
    rows.push_back(single_read(1, 4'd9, 4'd8, 8'h11, 4'b1000, 4'b1000, line_b[95:64]));
    rows.push_back(single_read(0, 4'd9, 4'd0, 8'h11, 4'b1000, 4'b1000, line_b[31:0]));

    cycle_limit = 4 * (rows.size() + 16) + 50;
    wait (rst_n === 1'b1);

    // clear the valid bit of every way in every set
    for (int s = 0; s < `DCACHE_NUM_SETS; s++) begin
      @(posedge clk);
      #1;
      cl_wr = line_write('1, 8'h00, idx_t'(s), '0, 4'b0000);
      cl_wr.be = '0;
    end

    for (int i = 0; i <= rows.size(); i++) begin
      @(posedge clk);
      #1;
      if (i < rows.size()) begin
        r = rows[i];
      end else begin
        r = idle_row();
      end
      rd_req  = r.rd_req;
      cl_wr   = r.cl_wr;
      word_wr = r.word_wr;
      rd_tag  = (i > 0) ? rows[i-1].rsp_tag : '0;
      #4;
      if (i > 0 && rows[i-1].chk_rsp) begin
        check_rsp(rd_rsp, rows[i-1].exp_rsp, rows[i-1].chk_data, i - 1);
      end
      if (i < rows.size()) begin
        check_ack(rd_ack, rows[i].exp_rd_ack, i);
        check_bit(wr_ack, rows[i].exp_wr_ack, i);
      end
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* build.f */
+incdir+common
common/dcache_pkg.sv
arbiter/dcache_rd_arbiter.sv
arbiter/dcache_bank_ctrl.sv
src/cache_sram.sv
src/dcache_hit_select.sv
src/dcache_mem.sv
testbench/tb_clk_gen.sv
testbench/tb_dcache_mem.sv
